// File: ins_extract.f
common/isa_pkg.sv
common/frontend_pkg.sv
extract/line_align.sv
extract/slot_mux.sv
extract/vec_expand.sv
verilog/bsr_detect.sv
extract/ins_extract.sv
testbench/tb_ins_extract.sv

// File: run_sim.sh
#!/bin/sh
# Build the instruction extract testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module tb_ins_extract \
	-f ins_extract.f -Mdir "$OBJ" -o sim_ins_extract
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ/sim_ins_extract" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	exit 1
fi
exit 0

// File: testbench/tb_ins_extract.sv
// Testbench for the instruction extract stage, random fetch groups checked against a queue model
`timescale 1ns/1ps
`default_nettype none

module tb_ins_extract;

	localparam int GROUPS = 400;
	localparam int CYCLE_LIMIT = GROUPS * 20 + 200;

	logic clk = 1'b0;
	logic rst_i;
	logic en_i;
	logic [511:0] line_i;
	frontend_pkg::pc_address_t pc_i;
	logic nop_i;
	logic branchmiss_i;
	frontend_pkg::pc_address_t misspc_i;
	logic hirq_i;
	logic [8:0] vect_i;
	logic mipv_i;
	frontend_pkg::mc_address_t mip_i;
	isa_pkg::instruction_t [3:0] mc_ins_i;
	logic [2:0] vl_i;
	logic get_i;
	logic stall_o;
	frontend_pkg::slot_t [3:0] out_o;
	logic [3:0] out_valid_o;
	logic do_bsr_o;
	frontend_pkg::pc_address_t bsr_tgt_o;

	logic [31:0] seed = 32'h574e_76d9;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int groups = 0;

	// The model keeps every expected entry in order, the registered group and the buffer count
	frontend_pkg::slot_t exp_q[$];
	frontend_pkg::slot_t pend[4];
	logic pend_valid = 1'b0;
	int pend_n = 0;
	int mcnt = 0;
	logic [3:0] exp_valid = '0;
	logic accepted = 1'b0;

	ins_extract dut (.*);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: %0d groups not drained within %0d cycles", GROUPS, CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	// ========================================================================
	// Random numbers and stimulus
	// ========================================================================

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rnd();
		seed = xorshift32(seed);
		return seed;
	endfunction

	function automatic logic chance(int pct);
		return (rnd() % 100) < pct;
	endfunction

	// Biased toward BSRs and vector opcodes so both paths see plenty of traffic
	function automatic logic [31:0] rand_word();
		logic [31:0] r;
		logic [6:0] op;
		r = rnd();
		case (rnd() % 8)
			0: op = isa_pkg::OP_NOP;
			1: op = isa_pkg::OP_BSR;
			2: op = isa_pkg::OP_ADD;
			3: op = isa_pkg::OP_XOR;
			4: op = isa_pkg::OP_VADD;
			5: op = isa_pkg::OP_VMUL;
			default: op = r[6:0];
		endcase
		return {r[31:7], op};
	endfunction

	// The fetch side redraws a group only once the previous one was taken or never offered
	task automatic drive_inputs(logic drain);
		int k;

		get_i = drain || chance(60);
		if (drain)
			en_i = 1'b0;
		else if (!en_i || accepted)
		begin
			en_i = chance(75);
			for (k = 0; k < 16; k++)
				line_i[32 * k +: 32] = rand_word();
			pc_i = rnd() & ~32'd3;
			nop_i = chance(5);
			branchmiss_i = chance(10);
			misspc_i = pc_i + 32'(4 * (rnd() % 6)) - 32'd4;
			hirq_i = chance(6);
			vect_i = 9'(rnd());
			mipv_i = chance(12);
			mip_i = 12'(rnd());
			for (k = 0; k < 4; k++)
				mc_ins_i[k] = isa_pkg::instruction_t'(rand_word());
			vl_i = 3'(rnd() % 4 + 1);
		end
	endtask

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic frontend_pkg::slot_t make_slot(logic [31:0] w,
		frontend_pkg::pc_address_t pc, frontend_pkg::mc_address_t mc);
		frontend_pkg::slot_t s;
		s.ins.ins = isa_pkg::instruction_t'(w);
		s.ins.rt = w[11:7];
		s.ins.ra = w[16:12];
		s.ins.rb = w[21:17];
		s.ins.rc = w[26:22];
		s.ins.vec = w[6] & w[5];
		s.pc = pc;
		s.mcip = mc;
		return s;
	endfunction

	task automatic accept_group();
		logic [31:0] w;
		frontend_pkg::pc_address_t pc;
		frontend_pkg::mc_address_t mc;
		frontend_pkg::slot_t el;
		int n;
		int k;
		int e;

		pend_n = 0;
		for (k = 0; k < 4; k++)
		begin
			pc = pc_i + 32'(4 * k);
			mc = '0;
			if (nop_i || (branchmiss_i && misspc_i > pc))
				w = isa_pkg::NOP_INS;
			else if (hirq_i && k == 0)
				w = {16'd0, vect_i, isa_pkg::OP_INT};
			else if (hirq_i)
				w = isa_pkg::NOP_INS;
			else if (mipv_i)
			begin
				w = mc_ins_i[k];
				mc = mip_i + 12'(k);
			end
			else
				w = line_i[32 * (int'(pc_i[4:2]) + k) +: 32];
			pend[k] = make_slot(w, pc, mc);
			n = pend[k].ins.vec ? int'(vl_i) : 1;
			for (e = 0; e < n; e++)
			begin
				el = pend[k];
				el.ins.rt = pend[k].ins.rt + 5'(e);
				el.ins.ra = pend[k].ins.ra + 5'(e);
				el.ins.rb = pend[k].ins.rb + 5'(e);
				exp_q.push_back(el);
				pend_n++;
			end
		end
		pend_valid = 1'b1;
		groups++;
	endtask

	// Replays the rising edge just past with the inputs that were applied to it
	task automatic model_edge();
		logic load;
		int take;
		int k;
		frontend_pkg::slot_t e;

		load = pend_valid && (mcnt == 0 || (get_i && mcnt <= 4));
		accepted = en_i && !(pend_valid && !load);
		if (get_i)
		begin
			take = (mcnt < 4) ? mcnt : 4;
			for (k = 0; k < 4; k++)
			begin
				exp_valid[k] = k < take;
				if (k < take)
				begin
					e = exp_q.pop_front();
					checks++;
					if (out_o[k] !== e)
					begin
						errors++;
						$display("[ERROR] %0t: out_o[%0d] is %h, expected %h", $time, k, out_o[k], e);
					end
				end
			end
			mcnt = mcnt - take;
		end
		if (load)
		begin
			mcnt = pend_n;
			pend_valid = 1'b0;
		end
		if (accepted)
			accept_group();
	endtask

	task automatic check_outputs();
		logic stall;
		logic found;
		frontend_pkg::pc_address_t tgt;
		logic [31:0] w;
		int k;

		stall = pend_valid && !(mcnt == 0 || (get_i && mcnt <= 4));
		found = 1'b0;
		tgt = frontend_pkg::RSTPC;
		// Lowest BSR wins, so scan from the top slot down
		for (k = 3; k >= 0; k--)
		begin
			w = pend[k].ins.ins;
			if (pend_valid && w[6:0] == isa_pkg::OP_BSR)
			begin
				found = 1'b1;
				tgt = pend[k].pc + {{7{w[31]}}, w[31:7]};
			end
		end
		checks++;
		if (stall_o !== stall || out_valid_o !== exp_valid)
		begin
			errors++;
			$display("[ERROR] %0t: stall_o %b out_valid_o %b, expected %b %b",
				$time, stall_o, out_valid_o, stall, exp_valid);
		end
		checks++;
		if (do_bsr_o !== found || bsr_tgt_o !== tgt)
		begin
			errors++;
			$display("[ERROR] %0t: do_bsr_o %b bsr_tgt_o %h, expected %b %h",
				$time, do_bsr_o, bsr_tgt_o, found, tgt);
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial
	begin
		rst_i = 1'b1;
		en_i = 1'b0;
		line_i = '0;
		pc_i = '0;
		nop_i = 1'b0;
		branchmiss_i = 1'b0;
		misspc_i = '0;
		hirq_i = 1'b0;
		vect_i = '0;
		mipv_i = 1'b0;
		mip_i = '0;
		mc_ins_i = '0;
		vl_i = 3'd1;
		get_i = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		checks++;
		if (stall_o !== 1'b0 || do_bsr_o !== 1'b0 || out_valid_o !== 4'b0)
		begin
			errors++;
			$display("[ERROR] %0t: outputs not cleared by reset", $time);
		end
		drive_inputs(1'b0);
		// After the last group the fetch side goes quiet and the buffer is drained
		while (groups < GROUPS || pend_valid || exp_q.size() != 0)
		begin
			@(negedge clk);
			model_edge();
			check_outputs();
			drive_inputs(groups >= GROUPS);
		end
		$display("groups %0d, checks %0d, errors %0d", groups, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: extract/ins_extract.sv
// Instruction extract stage: slot substitution, vector expansion and the drain buffer
`timescale 1ns/1ps
`default_nettype none

module ins_extract
(
	input  wire logic                                          clk,
	input  wire logic                                          rst_i,
	input  wire logic                                          en_i,
	input  wire logic [frontend_pkg::LINE_BITS-1:0]            line_i,
	input  wire frontend_pkg::pc_address_t                     pc_i,
	input  wire logic                                          nop_i,
	input  wire logic                                          branchmiss_i,
	input  wire frontend_pkg::pc_address_t                     misspc_i,
	input  wire logic                                          hirq_i,
	input  wire logic [8:0]                                    vect_i,
	input  wire logic                                          mipv_i,
	input  wire frontend_pkg::mc_address_t                     mip_i,
	input  wire isa_pkg::instruction_t [frontend_pkg::SLOTS-1:0] mc_ins_i,
	input  wire logic [2:0]                                    vl_i,
	input  wire logic                                          get_i,
	output logic                                               stall_o,
	output frontend_pkg::slot_t [frontend_pkg::SLOTS-1:0]      out_o,
	output logic [frontend_pkg::SLOTS-1:0]                     out_valid_o,
	output logic                                               do_bsr_o,
	output frontend_pkg::pc_address_t                          bsr_tgt_o
);

	frontend_pkg::slot_t [frontend_pkg::SLOTS-1:0] fetch_slot;
	frontend_pkg::slot_t [frontend_pkg::SLOTS-1:0] grp_slot;
	logic [frontend_pkg::SLOTS-1:0] grp_valid;
	logic grp_vld;
	logic accept;
	logic load;
	logic [2:0] vl_q;
	frontend_pkg::slot_t [frontend_pkg::EXP_DEPTH-1:0] exp_list;
	frontend_pkg::slot_t [frontend_pkg::EXP_DEPTH-1:0] dbuf_q;
	frontend_pkg::count_t exp_cnt;
	frontend_pkg::count_t cnt_q;
	frontend_pkg::count_t take;

	// ========================================================================
	// Group register
	// ========================================================================

	line_align u_align (.line_i(line_i), .pc_i(pc_i), .slot_o(fetch_slot));

	// Slot 0 takes the interrupt and the other slots are squashed behind it
	for (genvar k = 0; k < frontend_pkg::SLOTS; k++)
	begin : g_slot
		slot_mux u_slot (
			.clk(clk), .rst_i(rst_i), .adv_i(accept), .clr_i(load),
			.nop_i(nop_i || (hirq_i && k != 0)), .branchmiss_i(branchmiss_i),
			.misspc_i(misspc_i), .hirq_i(hirq_i && k == 0), .vect_i(vect_i),
			.mipv_i(mipv_i), .mcip_i(mip_i + frontend_pkg::mc_address_t'(k)),
			.mc_ins_i(mc_ins_i[k]), .fetch_i(fetch_slot[k]),
			.slot_o(grp_slot[k]), .valid_o(grp_valid[k])
		);
	end

	always_comb
		grp_vld = &grp_valid;

	always_ff @(posedge clk)
	begin
		if (accept)
			vl_q <= vl_i;
	end

	vec_expand u_expand (
		.clk(clk), .rst_i(rst_i), .slot_i(grp_slot), .valid_i(grp_vld),
		.vl_i(vl_q), .exp_o(exp_list), .count_o(exp_cnt)
	);

	bsr_detect u_bsr (
		.slot_i(grp_slot), .valid_i(grp_vld), .do_bsr_o(do_bsr_o), .bsr_tgt_o(bsr_tgt_o)
	);

	// ========================================================================
	// Drain buffer and load control
	// ========================================================================

	// A load needs the buffer empty after this edge's get
	always_comb
	begin
		load    = grp_vld && (cnt_q == '0 ||
			(get_i && cnt_q <= frontend_pkg::count_t'(frontend_pkg::SLOTS)));
		stall_o = grp_vld && !load;
		accept  = en_i && !stall_o;
		take    = (cnt_q < frontend_pkg::count_t'(frontend_pkg::SLOTS)) ?
			cnt_q : frontend_pkg::count_t'(frontend_pkg::SLOTS);
	end

	always_ff @(posedge clk)
	begin
		int i;

		if (load)
			dbuf_q <= exp_list;
		else if (get_i)
		begin
			for (i = 0; i < frontend_pkg::EXP_DEPTH; i++)
			begin
				if (i + int'(take) < frontend_pkg::EXP_DEPTH)
					dbuf_q[i] <= dbuf_q[i + int'(take)];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			cnt_q <= '0;
		else if (load)
			cnt_q <= exp_cnt;
		else if (get_i)
			cnt_q <= cnt_q - take;
	end

	// Issue sees the head of the buffer; unused slots are flagged invalid
	always_ff @(posedge clk)
	begin
		if (get_i)
			out_o <= dbuf_q[frontend_pkg::SLOTS-1:0];
	end

	always_ff @(posedge clk)
	begin
		int k;

		if (rst_i)
			out_valid_o <= '0;
		else if (get_i)
		begin
			for (k = 0; k < frontend_pkg::SLOTS; k++)
				out_valid_o[k] <= frontend_pkg::count_t'(k) < take;
		end
	end

	a_cnt_bound: assert property (@(posedge clk) disable iff (rst_i)
		cnt_q <= frontend_pkg::count_t'(frontend_pkg::EXP_DEPTH));

	// A stalled group is neither loaded nor overwritten by the fetch side
	a_stall_holds: assert property (@(posedge clk) disable iff (rst_i)
		stall_o |=> (grp_vld && $stable(grp_slot)));

endmodule

`default_nettype wire

// File: verilog/bsr_detect.sv
// BSR detector: finds the first branch-to-subroutine in the group and its target
`timescale 1ns/1ps
`default_nettype none

module bsr_detect
(
	input  wire frontend_pkg::slot_t [frontend_pkg::SLOTS-1:0] slot_i,
	input  wire logic                                         valid_i,
	output logic                                              do_bsr_o,
	output frontend_pkg::pc_address_t                         bsr_tgt_o
);

	logic [frontend_pkg::SLOTS-1:0] is_bsr;
	frontend_pkg::pc_address_t [frontend_pkg::SLOTS-1:0] tgt;

	// Targets for every slot are formed in parallel
	always_comb
	begin
		int k;

		for (k = 0; k < frontend_pkg::SLOTS; k++)
		begin
			is_bsr[k] = valid_i && slot_i[k].ins.ins.opcode == isa_pkg::OP_BSR;
			tgt[k]    = slot_i[k].pc + isa_pkg::bsr_disp(slot_i[k].ins.ins);
		end
	end

	always_comb
		do_bsr_o = |is_bsr;

	// Walk from the top slot down so the lowest BSR ends up selected
	always_comb
	begin
		int k;

		bsr_tgt_o = frontend_pkg::RSTPC;
		for (k = frontend_pkg::SLOTS - 1; k >= 0; k--)
		begin
			if (is_bsr[k])
				bsr_tgt_o = tgt[k];
		end
	end

endmodule

`default_nettype wire

// File: extract/vec_expand.sv
// Vector expander: unrolls vector slots into element instructions packed in slot order
`timescale 1ns/1ps
`default_nettype none

module vec_expand
(
	input  wire logic                                         clk,
	input  wire logic                                         rst_i,
	input  wire frontend_pkg::slot_t [frontend_pkg::SLOTS-1:0] slot_i,
	input  wire logic                                         valid_i,
	input  wire logic [2:0]                                   vl_i,
	output frontend_pkg::slot_t [frontend_pkg::EXP_DEPTH-1:0] exp_o,
	output frontend_pkg::count_t                              count_o
);

	logic [frontend_pkg::SLOTS-1:0] vec_flags;

	always_comb
	begin
		int k;

		for (k = 0; k < frontend_pkg::SLOTS; k++)
			vec_flags[k] = slot_i[k].ins.vec;
	end

	// ========================================================================
	// Element list
	// ========================================================================

	// Each element steps rt, ra and rb by its index and keeps rc, pc and mcip
	always_comb
	begin
		int s;
		int e;
		logic [2:0] n;
		frontend_pkg::count_t idx;
		frontend_pkg::slot_t el;

		exp_o = '0;
		idx   = '0;
		el    = '0;
		for (s = 0; s < frontend_pkg::SLOTS; s++)
		begin
			n = slot_i[s].ins.vec ? vl_i : 3'd1;
			for (e = 0; e < frontend_pkg::MAX_VL; e++)
			begin
				if (valid_i && e < int'(n))
				begin
					el        = slot_i[s];
					el.ins.rt = slot_i[s].ins.rt + 5'(e);
					el.ins.ra = slot_i[s].ins.ra + 5'(e);
					el.ins.rb = slot_i[s].ins.rb + 5'(e);
					// Loop bounds cap the list at EXP_DEPTH entries
					exp_o[idx[3:0]] = el;
					idx = idx + frontend_pkg::count_t'(1);
				end
			end
		end
		count_o = idx;
	end

	// The vector length is captured with the group on the fetch side
	a_vl_legal: assert property (@(posedge clk) disable iff (rst_i)
		(valid_i && |vec_flags) |-> (vl_i >= 3'd1 && vl_i <= 3'(frontend_pkg::MAX_VL)));

endmodule

`default_nettype wire

// File: extract/slot_mux.sv
// Slot register: substitutes squash NOPs, interrupts or micro-code into one fetch slot
`timescale 1ns/1ps
`default_nettype none

module slot_mux
(
	input  wire logic                      clk,
	input  wire logic                      rst_i,
	input  wire logic                      adv_i,
	input  wire logic                      clr_i,
	input  wire logic                      nop_i,
	input  wire logic                      branchmiss_i,
	input  wire frontend_pkg::pc_address_t misspc_i,
	input  wire logic                      hirq_i,
	input  wire logic [8:0]                vect_i,
	input  wire logic                      mipv_i,
	input  wire frontend_pkg::mc_address_t mcip_i,
	input  wire isa_pkg::instruction_t     mc_ins_i,
	input  wire frontend_pkg::slot_t       fetch_i,
	output frontend_pkg::slot_t            slot_o,
	output logic                           valid_o
);

	frontend_pkg::slot_t nxt;
	logic squash;

	// Anything ahead of the miss address belongs to the wrong path
	always_comb
		squash = nop_i || (branchmiss_i && misspc_i > fetch_i.pc);

	// ========================================================================
	// Substitution, highest priority first
	// ========================================================================

	always_comb
	begin
		nxt.pc = fetch_i.pc;
		if (squash)
		begin
			nxt.ins  = isa_pkg::predecode(isa_pkg::NOP_INS);
			nxt.mcip = '0;
		end
		else if (hirq_i)
		begin
			// The vector number rides in the displacement field of the INT
			nxt.ins  = isa_pkg::predecode(
				isa_pkg::instruction_t'({16'd0, vect_i, isa_pkg::OP_INT}));
			nxt.mcip = '0;
		end
		else if (mipv_i)
		begin
			nxt.ins  = isa_pkg::predecode(mc_ins_i);
			nxt.mcip = mcip_i;
		end
		else
		begin
			nxt.ins  = fetch_i.ins;
			nxt.mcip = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (adv_i)
			slot_o <= nxt;
	end

	// A new group takes priority over the load that drains the old one
	always_ff @(posedge clk)
	begin
		if (rst_i)
			valid_o <= 1'b0;
		else if (adv_i)
			valid_o <= 1'b1;
		else if (clr_i)
			valid_o <= 1'b0;
	end

	// The top only loads a registered group, so a drain never meets an empty slot
	a_clr_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
		!(adv_i && clr_i && !valid_o));

endmodule

`default_nettype wire

// File: extract/line_align.sv
// Line aligner: cuts four words out of the line pair at the fetch PC and pre-decodes them
`timescale 1ns/1ps
`default_nettype none

module line_align
(
	input  wire logic [frontend_pkg::LINE_BITS-1:0]        line_i,
	input  wire frontend_pkg::pc_address_t                 pc_i,
	output frontend_pkg::slot_t [frontend_pkg::SLOTS-1:0]  slot_o
);

	logic [frontend_pkg::SLOTS*32-1:0] aligned;

	// PC bits 4:2 pick the starting word; four words always fit in the pair
	always_comb
		aligned = (frontend_pkg::SLOTS*32)'(line_i >> {pc_i[4:2], 5'd0});

	always_comb
	begin
		int k;

		for (k = 0; k < frontend_pkg::SLOTS; k++)
		begin
			slot_o[k].ins  = isa_pkg::predecode(isa_pkg::instruction_t'(aligned[k*32 +: 32]));
			slot_o[k].pc   = pc_i + frontend_pkg::pc_address_t'(4 * k);
			// Fetched words never come from micro-code
			slot_o[k].mcip = '0;
		end
	end

endmodule

`default_nettype wire

// File: common/frontend_pkg.sv
// Front-end address types, slot payload and sizing constants
`default_nettype none

package frontend_pkg;

	// ========================================================================
	// Sizes
	// ========================================================================

	// Instructions handled per fetch group and per get
	localparam int SLOTS = 4;

	// Two 256-bit cache lines side by side
	localparam int LINE_BITS = 512;

	// Worst case is four vector instructions at the longest vector length
	localparam int EXP_DEPTH = 16;
	localparam int MAX_VL = 4;

	// ========================================================================
	// Addresses
	// ========================================================================

	typedef logic [31:0] pc_address_t;

	// A zero micro-code address marks an ordinary instruction
	typedef logic [11:0] mc_address_t;

	localparam pc_address_t RSTPC = 32'hFFFC_0000;

	// Entry count of the drain buffer, wide enough to hold EXP_DEPTH itself
	typedef logic [$clog2(EXP_DEPTH + 1)-1:0] count_t;

	// ========================================================================
	// Slot payload
	// ========================================================================

	typedef struct packed {
		isa_pkg::ex_instruction_t ins;
		pc_address_t              pc;
		mc_address_t              mcip;
	} slot_t;

endpackage

`default_nettype wire

// File: common/isa_pkg.sv
// ISA definitions for the front end: instruction format, opcodes and pre-decode
`default_nettype none

package isa_pkg;

	// Opcodes with both top bits set are vector operations
	typedef enum logic [6:0] {
		OP_NOP  = 7'h00,
		OP_INT  = 7'h01,
		OP_BSR  = 7'h02,
		OP_ADD  = 7'h10,
		OP_SUB  = 7'h11,
		OP_AND  = 7'h12,
		OP_OR   = 7'h13,
		OP_XOR  = 7'h14,
		OP_VADD = 7'h60,
		OP_VSUB = 7'h61,
		OP_VMUL = 7'h62
	} opcode_t;

	// Register format; a BSR reuses bits 31:7 as a signed byte displacement
	typedef struct packed {
		logic [4:0] ext;
		logic [4:0] rc;
		logic [4:0] rb;
		logic [4:0] ra;
		logic [4:0] rt;
		opcode_t    opcode;
	} instruction_t;

	typedef struct packed {
		instruction_t ins;
		logic [4:0]   rt;
		logic [4:0]   ra;
		logic [4:0]   rb;
		logic [4:0]   rc;
		logic         vec;
	} ex_instruction_t;

	localparam instruction_t NOP_INS = '{
		ext: 5'd0, rc: 5'd0, rb: 5'd0, ra: 5'd0, rt: 5'd0, opcode: OP_NOP
	};

	function automatic logic is_vector(opcode_t op);
		return op[6] & op[5];
	endfunction

	// Pulls the register fields out so later stages can rename them
	function automatic ex_instruction_t predecode(instruction_t ins);
		ex_instruction_t ex;
		ex.ins = ins;
		ex.rt  = ins.rt;
		ex.ra  = ins.ra;
		ex.rb  = ins.rb;
		ex.rc  = ins.rc;
		ex.vec = is_vector(ins.opcode);
		return ex;
	endfunction

	function automatic logic [31:0] bsr_disp(instruction_t ins);
		logic [31:0] w;
		w = ins;
		return {{7{w[31]}}, w[31:7]};
	endfunction

endpackage

`default_nettype wire
